/* source/lcd_pkg.sv */
package lcd_pkg;

    localparam int AXI_AW    = 8;
    localparam int ROM_DEPTH = 32;
    localparam int ROM_AW    = 5;

    localparam logic [AXI_AW-1:0] REG_CTRL     = 8'h00;
    localparam logic [AXI_AW-1:0] REG_STATUS   = 8'h04;
    localparam logic [AXI_AW-1:0] REG_BG_COLOR = 8'h08;
    localparam logic [AXI_AW-1:0] REG_PIXEL    = 8'h0C;
    localparam logic [AXI_AW-1:0] REG_CMD      = 8'h10;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // one word on the panel bus
    typedef struct packed {
        logic        rs;   // 0 command, 1 parameter or pixel
        logic [15:0] data;
    } lcd_word_t;

    typedef enum logic [1:0] {
        CMD   = 2'd0,
        PARAM = 2'd1,
        DELAY = 2'd2,
        END   = 2'd3
    } rom_kind_e;

    typedef struct packed {
        logic [3:0]  rsvd;
        logic [11:0] count;   // in delay units
    } rom_delay_t;

    typedef union packed {
        logic [15:0] data;
        rom_delay_t  delay;
    } rom_body_u;

    typedef struct packed {
        rom_kind_e kind;
        rom_body_u body;
    } rom_entry_t;

endpackage

/* source/lcd_axil_regs.sv */
`timescale 1ns/10ps
module lcd_axil_regs import lcd_pkg::*; (
    input  logic              pclk,
    input  logic              rst_n,
    input  logic [AXI_AW-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready,
    output axil_resp_e        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [AXI_AW-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output axil_resp_e        rresp,
    output logic              rvalid,
    input  logic              rready,
    output logic              start,
    output logic [15:0]       bg_color,
    output lcd_word_t         host_word,
    output logic              host_valid,
    input  logic              host_ready,
    input  logic              busy,
    input  logic              done
);
    logic       aw_hs;
    logic       ar_hs;
    logic       host_fire;
    logic       wr_host;
    logic       wr_ok;
    logic [31:0] rd_data;
    axil_resp_e  rd_resp;

    // one write in flight, host word included
    assign aw_hs     = awvalid && wvalid && !bvalid && !host_valid;
    assign awready   = aw_hs;
    assign wready    = aw_hs;
    assign ar_hs     = arvalid && !rvalid;
    assign arready   = ar_hs;
    assign host_fire = host_valid && host_ready;

    assign wr_host = (awaddr == REG_PIXEL) || (awaddr == REG_CMD);
    assign wr_ok   = (awaddr == REG_CTRL) || (awaddr == REG_BG_COLOR) || (wr_host && done);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            bvalid     <= 1'b0;
            host_valid <= 1'b0;
            start      <= 1'b0;
            bg_color   <= '0;
        end else begin
            start <= 1'b0;
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (host_fire) begin
                host_valid <= 1'b0;
                bvalid     <= 1'b1;   // response waits for the sequencer
            end
            if (aw_hs) begin
                if (wr_host && done)
                    host_valid <= 1'b1;
                else
                    bvalid <= 1'b1;
                if (awaddr == REG_CTRL && wstrb[0] && wdata[0] && !busy)
                    start <= 1'b1;
                if (awaddr == REG_BG_COLOR && wstrb[0])
                    bg_color[7:0] <= wdata[7:0];
                if (awaddr == REG_BG_COLOR && wstrb[1])
                    bg_color[15:8] <= wdata[15:8];
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (aw_hs) begin
            bresp <= wr_ok ? OKAY : SLVERR;
            if (wr_host) begin
                host_word.rs   <= (awaddr == REG_PIXEL);
                host_word.data <= wdata[15:0];
            end
        end
    end

    always_comb begin
        rd_data = '0;
        rd_resp = OKAY;
        case (araddr)
            REG_CTRL, REG_PIXEL, REG_CMD: rd_data = '0;   // write only, reads as zero
            REG_STATUS:   rd_data[1:0]  = {done, busy};
            REG_BG_COLOR: rd_data[15:0] = bg_color;
            default:      rd_resp = SLVERR;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (!rst_n)
            rvalid <= 1'b0;
        else if (ar_hs)
            rvalid <= 1'b1;
        else if (rvalid && rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge pclk) begin
        if (ar_hs) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    a_host_word_hold: assert property (@(posedge pclk) disable iff (!rst_n)
        host_valid && !host_ready |=> $stable(host_word));

    a_bvalid_req: assert property (@(posedge pclk) disable iff (!rst_n)
        $rose(bvalid) |-> $past(aw_hs || host_fire));

    a_rvalid_req: assert property (@(posedge pclk) disable iff (!rst_n)
        $rose(rvalid) |-> $past(ar_hs));

endmodule

/* source/lcd_init_seq.sv */
`timescale 1ns/10ps
module lcd_init_seq import lcd_pkg::*; #(
    parameter int H_RES      = 320,
    parameter int V_RES      = 240,
    parameter int DELAY_UNIT = 1000
) (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [15:0] bg_color,
    input  lcd_word_t   host_word,
    input  logic        host_valid,
    output logic        host_ready,
    output logic        busy,
    output logic        done,
    output lcd_word_t   word,
    output logic        word_valid,
    input  logic        word_ready
);
    localparam int NPIX = H_RES * V_RES;
    localparam int PW   = $clog2(NPIX);
    localparam int UW   = $clog2(DELAY_UNIT + 1);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        SEND,
        WAIT,
        FILL,
        READY
    } state_e;

    state_e            state;
    rom_entry_t        rom [ROM_DEPTH];
    rom_entry_t        rom_q;
    logic [ROM_AW-1:0] rom_addr;
    logic [11:0]       dly_cnt;
    logic [UW-1:0]     unit_cnt;
    logic [PW-1:0]     pix_cnt;
    logic [15:0]       fill_color;
    logic              rom_word;
    logic              go;

    initial $readmemh("source/lcd_init_rom.hex", rom);

    always_ff @(posedge pclk) begin
        rom_q <= rom[rom_addr];   // one cycle read
    end

    assign rom_word = (rom_q.kind == CMD) || (rom_q.kind == PARAM);
    assign go       = start && (state == IDLE || state == READY);

    always_comb begin
        word       = host_word;
        word_valid = 1'b0;
        case (state)
            SEND: begin
                word.rs    = (rom_q.kind == PARAM);
                word.data  = rom_q.body.data;
                word_valid = rom_word;
            end
            FILL: begin
                word.rs    = 1'b1;
                word.data  = fill_color;
                word_valid = 1'b1;
            end
            READY:   word_valid = host_valid;   // host words pass straight on
            default: word_valid = 1'b0;
        endcase
    end

    assign host_ready = (state == READY) && word_ready;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state    <= IDLE;
            rom_addr <= '0;
            dly_cnt  <= '0;
            unit_cnt <= '0;
            pix_cnt  <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
        end else begin
            case (state)
                IDLE, READY: begin
                    if (go) begin
                        state    <= FETCH;
                        rom_addr <= '0;
                        busy     <= 1'b1;
                        done     <= 1'b0;
                    end
                end
                FETCH: state <= SEND;
                SEND: begin
                    case (rom_q.kind)
                        CMD, PARAM: begin
                            if (word_ready) begin
                                rom_addr <= rom_addr + 1'b1;
                                state    <= FETCH;
                            end
                        end
                        DELAY: begin
                            dly_cnt  <= rom_q.body.delay.count;
                            unit_cnt <= UW'(DELAY_UNIT - 1);
                            state    <= WAIT;
                        end
                        default: begin   // end of table
                            pix_cnt <= '0;
                            state   <= FILL;
                        end
                    endcase
                end
                WAIT: begin
                    if (dly_cnt == '0) begin
                        rom_addr <= rom_addr + 1'b1;
                        state    <= FETCH;
                    end else if (unit_cnt == '0) begin
                        unit_cnt <= UW'(DELAY_UNIT - 1);
                        dly_cnt  <= dly_cnt - 1'b1;
                    end else begin
                        unit_cnt <= unit_cnt - 1'b1;
                    end
                end
                FILL: begin
                    if (word_ready) begin
                        if (pix_cnt == PW'(NPIX - 1)) begin
                            state <= READY;
                            busy  <= 1'b0;
                            done  <= 1'b1;
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // colour latched so a host write during fill has no effect on it
    always_ff @(posedge pclk) begin
        if (go)
            fill_color <= bg_color;
    end

    a_no_word_in_wait: assert property (@(posedge pclk) disable iff (!rst_n)
        state == WAIT |-> !word_valid);

endmodule

/* source/lcd_bus_writer.sv */
`timescale 1ns/10ps
module lcd_bus_writer import lcd_pkg::*; #(
    parameter int WR_LOW  = 2,
    parameter int WR_HIGH = 2
) (
    input  logic        pclk,
    input  logic        rst_n,
    input  lcd_word_t   word,
    input  logic        word_valid,
    output logic        word_ready,
    output logic        cs_n,
    output logic        rs,
    output logic        wr_n,
    output logic [15:0] data
);
    localparam int CW = $clog2(WR_LOW + WR_HIGH + 1);

    logic [CW-1:0] phase;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            word_ready <= 1'b0;
            phase      <= CW'(WR_LOW + WR_HIGH - 1);   // ready one cycle after reset
            cs_n       <= 1'b1;
            wr_n       <= 1'b1;
        end else if (word_ready) begin
            if (word_valid) begin
                word_ready <= 1'b0;
                phase      <= '0;
                cs_n       <= 1'b0;
                wr_n       <= 1'b0;
            end
        end else begin
            phase <= phase + 1'b1;
            if (phase == CW'(WR_LOW - 1))
                wr_n <= 1'b1;   // panel latches here
            if (phase == CW'(WR_LOW + WR_HIGH - 1)) begin
                word_ready <= 1'b1;
                cs_n       <= 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (word_valid && word_ready) begin
            data <= word.data;
            rs   <= word.rs;
        end
    end

    a_bus_stable: assert property (@(posedge pclk) disable iff (!rst_n)
        !cs_n && $past(!cs_n) |-> $stable(data) && $stable(rs));

endmodule

/* source/lcd_ctrl_top.sv */
`timescale 1ns/10ps
module lcd_ctrl_top import lcd_pkg::*; #(
    parameter int H_RES      = 320,
    parameter int V_RES      = 240,
    parameter int DELAY_UNIT = 1000,
    parameter int WR_LOW     = 2,
    parameter int WR_HIGH    = 2
) (
    input  logic              pclk,
    input  logic              rst_n,
    input  logic [AXI_AW-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready,
    output axil_resp_e        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [AXI_AW-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output axil_resp_e        rresp,
    output logic              rvalid,
    input  logic              rready,
    output logic              cs_n,
    output logic              rs,
    output logic              wr_n,
    output logic [15:0]       data
);
    logic        start;
    logic [15:0] bg_color;
    lcd_word_t   host_word;
    logic        host_valid;
    logic        host_ready;
    logic        busy;
    logic        done;
    lcd_word_t   word;
    logic        word_valid;
    logic        word_ready;

    lcd_axil_regs i_regs (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .start      (start),
        .bg_color   (bg_color),
        .host_word  (host_word),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .busy       (busy),
        .done       (done)
    );

    lcd_init_seq #(
        .H_RES      (H_RES),
        .V_RES      (V_RES),
        .DELAY_UNIT (DELAY_UNIT)
    ) i_seq (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .start      (start),
        .bg_color   (bg_color),
        .host_word  (host_word),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .busy       (busy),
        .done       (done),
        .word       (word),
        .word_valid (word_valid),
        .word_ready (word_ready)
    );

    lcd_bus_writer #(
        .WR_LOW  (WR_LOW),
        .WR_HIGH (WR_HIGH)
    ) i_writer (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .word       (word),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .cs_n       (cs_n),
        .rs         (rs),
        .wr_n       (wr_n),
        .data       (data)
    );

endmodule

/* dv/tb_lcd_ctrl.sv */
`timescale 1ns/10ps
module tb_lcd_ctrl import lcd_pkg::*; ();

    localparam int          H_RES      = 8;
    localparam int          V_RES      = 4;
    localparam int          DELAY_UNIT = 4;
    localparam int          WR_LOW     = 2;
    localparam int          WR_HIGH    = 2;
    localparam int          NPIX       = H_RES * V_RES;
    localparam int          CLK_NS     = 4;
    localparam longint      UNIT_NS    = longint'(DELAY_UNIT * CLK_NS);
    localparam logic [15:0] LFSR_SEED  = 16'd21223;

    logic              pclk;
    logic              rst_n;
    logic [AXI_AW-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              wvalid;
    logic              wready;
    axil_resp_e        bresp;
    logic              bvalid;
    logic              bready;
    logic [AXI_AW-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [31:0]       rdata;
    axil_resp_e        rresp;
    logic              rvalid;
    logic              rready;
    logic              cs_n;
    logic              rs;
    logic              wr_n;
    logic [15:0]       data;

    logic [17:0] rom_img [ROM_DEPTH];
    lcd_word_t   exp_rom[$];   // cmd and param words in table order
    int          dly_pos[$];   // index of the word that follows a delay
    int          dly_units[$];
    int          dly_total;
    lcd_word_t   cap_q[$];
    longint      cap_t[$];
    logic [15:0] lfsr;
    int          init_base;
    int          wd_cycles;
    int          word_errs;
    int          resp_errs;
    int          status_errs;
    int          other_errs;

    lcd_ctrl_top #(
        .H_RES      (H_RES),
        .V_RES      (V_RES),
        .DELAY_UNIT (DELAY_UNIT),
        .WR_LOW     (WR_LOW),
        .WR_HIGH    (WR_HIGH)
    ) i_dut (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cs_n    (cs_n),
        .rs      (rs),
        .wr_n    (wr_n),
        .data    (data)
    );

    initial begin
        pclk = 1'b0;
        forever #(CLK_NS / 2) pclk = ~pclk;
    end

    // panel latches on the rising strobe
    always @(posedge wr_n) begin
        if (rst_n === 1'b1) begin   // wr_n leaves X during reset
            cap_q.push_back(make_word(rs, data));
            cap_t.push_back(longint'($time));
        end
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge pclk);
        $display("timeout: run did not finish within %0d cycles", wd_cycles);
        $display("Test FAILED");
        $finish;
    end

    function automatic lcd_word_t make_word(input logic rs_bit, input logic [15:0] val);
        lcd_word_t w;
        w.rs   = rs_bit;
        w.data = val;
        return w;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_word(input lcd_word_t got, input lcd_word_t exp, input string what);
        if (got !== exp) begin
            word_errs++;
            $display("CHECK FAILED t=%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input axil_resp_e got, input axil_resp_e exp, input string what);
        if (got !== exp) begin
            resp_errs++;
            $display("CHECK FAILED t=%0t: %s response %s expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_status(input logic [31:0] got, input logic exp_busy,
                                input logic exp_done);
        logic [31:0] exp;
        exp = {30'd0, exp_done, exp_busy};
        if (got !== exp) begin
            status_errs++;
            $display("CHECK FAILED t=%0t: status %h expected %h", $time, got, exp);
        end
    endtask

    task automatic other_error(input string msg);
        other_errs++;
        $display("ERROR t=%0t: %s", $time, msg);
    endtask

    task automatic axil_write(input logic [AXI_AW-1:0] addr, input logic [31:0] val,
                              input axil_resp_e exp, input string what);
        @(negedge pclk);
        awaddr  = addr;
        wdata   = val;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!awready) begin
            @(negedge pclk);
            #1;
        end
        if (wready !== 1'b1)
            other_error("write data not accepted together with the address");
        @(negedge pclk);   // taken on the edge in between
        awvalid = 1'b0;
        wvalid  = 1'b0;
        #1;
        while (!bvalid) begin
            @(negedge pclk);
            #1;
        end
        check_resp(bresp, exp, what);
        @(posedge pclk);   // bready is held high
    endtask

    task automatic axil_read(input logic [AXI_AW-1:0] addr, input axil_resp_e exp,
                             output logic [31:0] val);
        @(negedge pclk);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge pclk);
            #1;
        end
        @(negedge pclk);
        arvalid = 1'b0;
        #1;
        while (!rvalid) begin
            @(negedge pclk);
            #1;
        end
        val = rdata;
        check_resp(rresp, exp, "register read");
        @(posedge pclk);
    endtask

    task automatic wait_bus_idle;
        @(negedge pclk);
        while (!(cs_n && wr_n))
            @(negedge pclk);
    endtask

    task automatic wait_done;
        logic [31:0] st;
        st = '0;
        while (!st[1])
            axil_read(REG_STATUS, OKAY, st);
        wait_bus_idle();   // last fill word still on the bus
    endtask

    task automatic build_expected;
        rom_kind_e kind;
        int        pend;
        logic      stop;
        pend      = 0;
        stop      = 1'b0;
        dly_total = 0;
        for (int i = 0; i < ROM_DEPTH && !stop; i++) begin
            kind = rom_kind_e'(rom_img[i][17:16]);
            if (kind == CMD || kind == PARAM) begin
                if (pend != 0) begin
                    dly_pos.push_back(exp_rom.size());
                    dly_units.push_back(pend);
                    pend = 0;
                end
                exp_rom.push_back(make_word(kind == PARAM, rom_img[i][15:0]));
            end else if (kind == DELAY) begin
                pend      += int'(rom_img[i][11:0]);
                dly_total += int'(rom_img[i][11:0]);
            end else begin
                stop = 1'b1;
            end
        end
    endtask

    task automatic check_stream(input int base, input logic [15:0] color);
        int n_fill;
        n_fill = cap_q.size() - base - exp_rom.size();
        if (n_fill != NPIX)
            other_error($sformatf("fill produced %0d words instead of %0d", n_fill, NPIX));
        for (int i = 0; i < exp_rom.size() && base + i < cap_q.size(); i++)
            check_word(cap_q[base + i], exp_rom[i], "table word");
        for (int i = base + exp_rom.size(); i < cap_q.size(); i++)
            check_word(cap_q[i], make_word(1'b1, color), "fill word");
    endtask

    task automatic test_reset;
        logic [31:0] st;
        @(negedge pclk);
        if (wr_n !== 1'b1 || cs_n !== 1'b1)
            other_error("wr_n or cs_n not high after reset");
        axil_read(REG_STATUS, OKAY, st);
        check_status(st, 1'b0, 1'b0);
        if (cap_q.size() != 0)
            other_error("panel word seen after reset");
    endtask

    task automatic test_early_errors;
        axil_write(REG_PIXEL, 32'h0000_1234, SLVERR, "pixel before done");
        axil_write(8'h14, 32'h0000_0001, SLVERR, "unknown offset");
        axil_write(REG_STATUS, 32'h0000_0003, SLVERR, "status write");
        repeat (10) @(negedge pclk);
        if (cap_q.size() != 0)
            other_error("rejected write reached the panel");
    endtask

    task automatic test_init;
        logic [31:0] st;
        init_base = cap_q.size();
        axil_write(REG_BG_COLOR, 32'h0000_A5C3, OKAY, "colour write");
        axil_write(REG_CTRL, 32'h0000_0001, OKAY, "start");
        wait_done();
        check_stream(init_base, 16'hA5C3);
        axil_read(REG_STATUS, OKAY, st);
        check_status(st, 1'b0, 1'b1);
    endtask

    task automatic test_delays;
        longint gap;
        longint need;
        for (int k = 0; k < dly_pos.size(); k++) begin
            if (dly_pos[k] > 0 && init_base + dly_pos[k] < cap_q.size()) begin
                gap  = cap_t[init_base + dly_pos[k]] - cap_t[init_base + dly_pos[k] - 1];
                need = longint'(dly_units[k]) * UNIT_NS;
                if (gap < need)
                    other_error($sformatf("delay %0d lasted %0d ns, needs %0d ns", k, gap, need));
            end
        end
    endtask

    task automatic test_host_writes;
        lcd_word_t   exp_q[$];
        logic [15:0] sel;
        logic [15:0] val;
        int          base;
        base = cap_q.size();
        for (int k = 0; k < 12; k++) begin
            take_bits(1, sel);
            take_bits(16, val);
            exp_q.push_back(make_word(sel[0], val));
            axil_write(sel[0] ? REG_PIXEL : REG_CMD, {16'h0, val}, OKAY, "host write");
        end
        wait_bus_idle();
        if (cap_q.size() != base + exp_q.size())
            other_error($sformatf("%0d host words on the panel, %0d written",
                                  cap_q.size() - base, exp_q.size()));
        for (int k = 0; k < exp_q.size() && base + k < cap_q.size(); k++)
            check_word(cap_q[base + k], exp_q[k], "host word");
    endtask

    task automatic test_start_busy;
        logic [31:0] st;
        int          base;
        base = cap_q.size();
        axil_write(REG_BG_COLOR, 32'h0000_3C5A, OKAY, "colour write");
        axil_write(REG_CTRL, 32'h0000_0001, OKAY, "restart");
        @(negedge pclk);
        while (cap_q.size() < base + exp_rom.size() + 2)   // fill under way
            @(negedge pclk);
        axil_read(REG_STATUS, OKAY, st);
        check_status(st, 1'b1, 1'b0);
        axil_write(REG_CTRL, 32'h0000_0001, OKAY, "start while busy");
        wait_done();
        check_stream(base, 16'h3C5A);
    endtask

    initial begin
        int total;
        rst_n       = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b1;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b1;
        lfsr        = LFSR_SEED;
        word_errs   = 0;
        resp_errs   = 0;
        status_errs = 0;
        other_errs  = 0;
        $readmemh("source/lcd_init_rom.hex", rom_img);
        build_expected();
        // two full init runs plus host traffic
        wd_cycles = 2 * ((ROM_DEPTH + NPIX + 64) * 8 + dly_total * DELAY_UNIT) + 10;
        repeat (10) @(posedge pclk);
        @(negedge pclk);
        rst_n = 1'b1;

        test_reset();
        test_early_errors();
        test_init();
        test_delays();
        test_host_writes();
        test_start_busy();

        total = word_errs + resp_errs + status_errs + other_errs;
        $display("errors: word %0d, response %0d, status %0d, other %0d",
                 word_errs, resp_errs, status_errs, other_errs);
        if (total == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* list.f */
source/lcd_pkg.sv
source/lcd_axil_regs.sv
source/lcd_init_seq.sv
source/lcd_bus_writer.sv
source/lcd_ctrl_top.sv
dv/tb_lcd_ctrl.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
LINT     := --lint-only --timing
TOP      := tb_lcd_ctrl
FLIST    := list.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Test FAILED
PASS_MSG := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* source/lcd_init_rom.hex */
// kind in the top digit (0 cmd, 1 param, 2 delay, 3 end), body in the low 16 bits
// a delay body holds its count of delay units in bits 11:0
00001
20005
00011
2000A
0003A
10055
00036
10048
0002A
10000
10000
10000
10007
0002B
10000
10000
10000
10003
00029
0002C
30000
